// ==== Makefile ====
SIM    := verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := tb_board_reset
FLIST  := flist.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), result from $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "test failed, no result in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/tb_board_reset.sv ====
`timescale 1ns/1ns

// testbench for board_reset_top
// local bus master, criteria model per step, pulse checker
module tb_board_reset;

	localparam int nstep      = 4;
	localparam int por_cycles = 100;
	localparam int max_polls  = 400;  // status reads before giving up
	// top done bit or any error ends a sequence
	localparam logic [31:0] end_mask = (32'h1 << (nstep - 1))
		| (((32'h1 << nstep) - 32'h1) << 16);

	logic               clk200 = 1'b0;
	logic               rst = 1'b1;
	reset_pkg::lb_cmd_t lbwcmd = '0;
	logic               lbwvalid = 1'b0;
	reset_pkg::lb_cmd_t lbrcmd;
	logic               lbrready;
	logic [nstep-1:0]   done_criteria = '0;  // driven by the device model
	logic [nstep-1:0]   reset_out;

	// device model state
	int               seed = 32'h3e85_8c70;
	logic [nstep-1:0] stuck = '0;   // criteria forced low
	logic [nstep-1:0] ro_q = '0;    // reset_out last cycle
	logic [nstep-1:0] armed = '0;   // delay running
	int               dly [nstep];

	// checker state
	int               exp_width = 10;  // expected reset pulse width
	int               width [nstep];
	int               rise_log [$];    // step index per rising reset_out
	logic [nstep-1:0] crit_at_cmd;     // criteria seen by the last read

	int errors;
	int errs_at_start;
	int tests_run;
	int tests_failed;

	board_reset_top #(
		.nstep      (nstep),
		.por_cycles (por_cycles)
	) i_board_reset_top (
		.clk200        (clk200),
		.rst           (rst),
		.lbwcmd        (lbwcmd),
		.lbwvalid      (lbwvalid),
		.lbrcmd        (lbrcmd),
		.lbrready      (lbrready),
		.done_criteria (done_criteria),
		.reset_out     (reset_out)
	);

	initial begin
		forever #10 clk200 = ~clk200;  // 20 ns
	end

	// hang guard
	initial begin
		#(20 * 40000);
		$display("simulation ran too long, sequence never finished");
		$display(">>> FAIL");
		$finish;
	end

	// device model, criteria low in reset, up 1..30 cycles after it falls
	always @(posedge clk200) begin
		logic [nstep-1:0] crit_nx;
		logic [nstep-1:0] armed_nx;
		int               d;
		crit_nx  = done_criteria;
		armed_nx = armed;
		for (int i = 0; i < nstep; i++) begin
			if (rst || reset_out[i]) begin
				crit_nx[i]  = 1'b0;
				armed_nx[i] = 1'b0;
			end else if (ro_q[i]) begin
				d = 1 + int'($unsigned($random(seed)) % 30);  // cycles from the fall
				if (d == 1) begin
					crit_nx[i] = ~stuck[i];
				end else begin
					dly[i]      <= d - 1;
					armed_nx[i] = 1'b1;
				end
			end else if (armed[i]) begin
				if (dly[i] <= 1) begin
					armed_nx[i] = 1'b0;
					crit_nx[i]  = ~stuck[i];  // a stuck device never locks
				end else begin
					dly[i] <= dly[i] - 1;
				end
			end
		end
		done_criteria <= crit_nx;
		armed         <= armed_nx;
		ro_q          <= reset_out;
	end

	// pulse checker, width on each fall, order log on each rise
	always @(posedge clk200) begin
		for (int i = 0; i < nstep; i++) begin
			if (reset_out[i]) begin
				if (width[i] == 0) begin
					rise_log.push_back(i);
				end
				width[i] = width[i] + 1;
			end else if (width[i] != 0) begin
				if (width[i] != exp_width) begin
					fail_value($sformatf("reset_out[%0d] width", i), width[i], exp_width);
				end
				width[i] = 0;
			end
		end
	end

	task automatic fail_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("[FAIL] %0t ns %s: expected 0x%0h, got 0x%0h", $time, name, exp, got);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// status word from the stuck steps and the timeout
	function automatic logic [31:0] expected_status(input logic [nstep-1:0] stuck_mask,
			input logic [31:0] tmo);
		logic [31:0] st;
		int first;
		st    = '0;
		first = nstep;   // no stuck step
		for (int i = nstep - 1; i >= 0; i--) begin
			if (stuck_mask[i]) first = i;
		end
		for (int i = 0; i < first; i++) begin
			st[i] = 1'b1;  // every step before the stuck one finishes
		end
		if (first < nstep && tmo != 0) begin
			st[16 + first] = 1'b1;
		end
		return st;
	endfunction

	task automatic bus_write(input reset_pkg::lb_addr_t addr, input reset_pkg::lb_data_t data);
		@(posedge clk200);
		lbwcmd   <= {1'b0, 7'd0, addr, data};
		lbwvalid <= 1'b1;
		@(posedge clk200);
		lbwvalid <= 1'b0;
		@(posedge clk200);
		if (lbrready) report_problem("read reply after a write command");
	endtask

	task automatic bus_read(input reset_pkg::lb_addr_t addr, output reset_pkg::lb_data_t data);
		reset_pkg::lb_cmd_t cmd;
		cmd = {1'b1, 7'd0, addr, 32'd0};
		@(posedge clk200);
		lbwcmd   <= cmd;
		lbwvalid <= 1'b1;
		@(posedge clk200);
		lbwvalid    <= 1'b0;
		crit_at_cmd = done_criteria;  // value the DUT samples with the command
		if (lbrready) report_problem("read reply came before its command was taken");
		@(posedge clk200);
		if (!lbrready) begin
			report_problem($sformatf("no read reply for address 0x%0h", addr));
		end
		if (lbrcmd[63:32] != cmd[63:32]) fail_value("lbrcmd[63:32]", lbrcmd[63:32], cmd[63:32]);
		data = lbrcmd[31:0];
	endtask

	task automatic write_read_back(input reset_pkg::lb_addr_t addr, input logic [31:0] data,
			input logic [31:0] mask, input string name);
		logic [31:0] rd;
		bus_write(addr, data);
		bus_read(addr, rd);
		if (rd != (data & mask)) fail_value(name, rd, data & mask);
	endtask

	// polls status until the mask hits or the poll budget runs out
	task automatic wait_status(input logic [31:0] mask, output logic [31:0] st);
		int polls;
		polls = 0;
		st    = '0;
		while ((st & mask) == 0 && polls < max_polls) begin
			bus_read(reset_pkg::addr_status, st);
			polls++;
		end
		if ((st & mask) == 0) begin
			report_problem($sformatf("sequence did not end within %0d status reads", polls));
		end
	endtask

	task automatic check_order(input int count);
		if (rise_log.size() != count) begin
			report_problem($sformatf("%0d reset pulses seen, %0d expected", rise_log.size(), count));
		end
		for (int i = 0; i < rise_log.size() && i < count; i++) begin
			if (rise_log[i] != i) fail_value("reset_out rise order", rise_log[i], i);
		end
	endtask

	task automatic check_criteria();
		logic [31:0] rd;
		bus_read(reset_pkg::addr_criteria, rd);
		if (rd != 32'(crit_at_cmd)) fail_value("criteria", rd, 32'(crit_at_cmd));
	endtask

	task automatic begin_test();
		tests_run++;
		errs_at_start = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == errs_at_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errs_at_start);
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] st;
		logic [31:0] tmo_val;
		tmo_val = 32'd0;
		repeat (5) @(posedge clk200);
		rst <= 1'b0;

		begin_test();  // power-on start, no bus writes
		wait_status(end_mask, st);
		check_order(nstep);
		if (st != expected_status(stuck, tmo_val))
			fail_value("status", st, expected_status(stuck, tmo_val));
		end_test("power-on sequence");

		begin_test();
		write_read_back(reset_pkg::addr_ready_len, 32'habcd_0011, 32'h0000_ffff, "ready_len");
		write_read_back(reset_pkg::addr_reset_len, 32'h0000_0021, 32'h0000_ffff, "reset_len");
		write_read_back(reset_pkg::addr_timeout, 32'h0001_2345, 32'hffff_ffff, "timeout");
		write_read_back(reset_pkg::addr_scratch, 32'ha5c3_0f96, 32'hffff_ffff, "scratch");
		bus_read(24'h00_0007, rd);  // past the map
		if (rd != 32'hdead_beef) fail_value("unused address data", rd, 32'hdead_beef);
		bus_read(24'h12_3456, rd);
		if (rd != 32'hdead_beef) fail_value("unused address data", rd, 32'hdead_beef);
		write_read_back(reset_pkg::addr_ready_len, 32'd10, 32'h0000_ffff, "ready_len");
		write_read_back(reset_pkg::addr_reset_len, 32'd10, 32'h0000_ffff, "reset_len");
		write_read_back(reset_pkg::addr_timeout, 32'd0, 32'hffff_ffff, "timeout");
		end_test("register access");

		begin_test();
		bus_write(reset_pkg::addr_reset_len, 32'd25);
		exp_width <= 25;
		rise_log.delete();
		bus_write(reset_pkg::addr_ctrl, 32'd1);  // software strobe
		wait_status(end_mask, st);
		check_order(nstep);
		if (st != expected_status(stuck, tmo_val))
			fail_value("status", st, expected_status(stuck, tmo_val));
		end_test("restart with new lengths");

		begin_test();
		tmo_val = 32'd200;
		bus_write(reset_pkg::addr_timeout, tmo_val);
		stuck[2] <= 1'b1;
		rise_log.delete();
		bus_write(reset_pkg::addr_ctrl, 32'd1);
		wait_status(end_mask, st);
		repeat (50) @(posedge clk200);  // step 3 must stay quiet
		check_order(2 + 1);
		if (st != expected_status(stuck, tmo_val))
			fail_value("status", st, expected_status(stuck, tmo_val));
		end_test("timeout on stuck step");

		begin_test();
		stuck <= '0;
		rise_log.delete();
		bus_write(reset_pkg::addr_ctrl, 32'd1);
		wait_status(end_mask, st);
		check_order(nstep);
		if (st != expected_status(stuck, tmo_val))
			fail_value("status", st, expected_status(stuck, tmo_val));
		end_test("restart recovery");

		begin_test();
		check_criteria();
		rise_log.delete();
		bus_write(reset_pkg::addr_ctrl, 32'd1);
		for (int n = 0; n < 40; n++) begin
			check_criteria();  // criteria moving while the chain runs
		end
		wait_status(end_mask, st);
		check_order(nstep);
		check_criteria();
		end_test("criteria readback");

		$display("tests run %0d, failed %0d, checks failed %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
source/reset_pkg.sv
source/reset_step.sv
source/chain_reset.sv
source/lb_regs.sv
source/board_reset_top.sv
bench/tb_board_reset.sv

// ==== source/board_reset_top.sv ====
`timescale 1ns/1ns

// bring-up reset sequencer, bus regs plus step chain
module board_reset_top #(
	parameter int nstep      = 4,    // at most 16, status packs 16 bits per half
	parameter int por_cycles = 100
) (
	input  logic                clk200,
	input  logic                rst,
	input  reset_pkg::lb_cmd_t  lbwcmd,
	input  logic                lbwvalid,
	output reset_pkg::lb_cmd_t  lbrcmd,
	output logic                lbrready,
	input  logic [nstep-1:0]    done_criteria,  // from the board devices
	output logic [nstep-1:0]    reset_out
);

	logic             seq_start;   // regs to chain
	reset_pkg::len_t  ready_len;
	reset_pkg::len_t  reset_len;
	reset_pkg::tmo_t  timeout;
	logic [nstep-1:0] done;        // chain back to regs
	logic [nstep-1:0] error;

	lb_regs #(
		.nstep (nstep)
	) i_lb_regs (
		.clk200        (clk200),
		.rst           (rst),
		.lbwcmd        (lbwcmd),
		.lbwvalid      (lbwvalid),
		.lbrcmd        (lbrcmd),
		.lbrready      (lbrready),
		.done          (done),
		.error         (error),
		.done_criteria (done_criteria),
		.seq_start     (seq_start),
		.ready_len     (ready_len),
		.reset_len     (reset_len),
		.timeout       (timeout)
	);

	chain_reset #(
		.nstep      (nstep),
		.por_cycles (por_cycles)
	) i_chain_reset (
		.clk200        (clk200),
		.rst           (rst),
		.seq_start     (seq_start),
		.done_criteria (done_criteria),
		.ready_len     (ready_len),
		.reset_len     (reset_len),
		.timeout       (timeout),
		.reset_out     (reset_out),
		.done          (done),
		.error         (error)
	);

endmodule

// ==== source/chain_reset.sv ====
`timescale 1ns/1ns

// nstep reset_step links in series
// plus power-on start after por_cycles
module chain_reset #(
	parameter int nstep      = 4,
	parameter int por_cycles = 100
) (
	input  logic              clk200,
	input  logic              rst,
	input  logic              seq_start,      // software strobe
	input  logic [nstep-1:0]  done_criteria,  // e.g. lock / resetdone flags
	input  reset_pkg::len_t   ready_len,      // shared by all steps
	input  reset_pkg::len_t   reset_len,
	input  reset_pkg::tmo_t   timeout,
	output logic [nstep-1:0]  reset_out,
	output logic [nstep-1:0]  done,
	output logic [nstep-1:0]  error
);

	localparam int por_w = $clog2(por_cycles + 1);

	logic [por_w-1:0] por_cnt;    // cycles since rst fell
	logic             por_fired;  // one shot per rst
	logic             por_pulse;
	logic             start;      // chain start, any source

	logic [nstep-1:0] done_strobe;
	logic [nstep-1:0] step_ready;
	logic [nstep-1:0] step_start;
	logic [nstep-1:0] step_rst;   // local clear per step

	// power-on start, lands por_cycles cycles after rst drops
	always_ff @(posedge clk200) begin
		if (rst) begin
			por_cnt   <= '0;
			por_fired <= 1'b0;
			por_pulse <= 1'b0;
		end else begin
			por_pulse <= 1'b0;
			if (!por_fired) begin
				if (por_cnt == por_w'(por_cycles - 1)) begin
					por_pulse <= 1'b1;
					por_fired <= 1'b1;
				end else begin
					por_cnt <= por_cnt + 1'b1;
				end
			end
		end
	end

	assign start = seq_start | por_pulse;

	for (genvar i = 0; i < nstep; i++) begin : g_step
		if (i == 0) begin : g_head
			assign step_ready[i] = 1'b1;   // head of chain always ready
			assign step_start[i] = start;
			assign step_rst[i]   = rst;    // start itself rearms this one
		end else begin : g_link
			assign step_ready[i] = done_criteria[i-1];
			assign step_start[i] = done_strobe[i-1];
			// a new start drops later steps back to idle
			assign step_rst[i]   = rst | start;
		end

		reset_step i_reset_step (
			.clk200      (clk200),
			.rst         (step_rst[i]),
			.start       (step_start[i]),
			.ready_in    (step_ready[i]),
			.criteria    (done_criteria[i]),
			.ready_len   (ready_len),
			.reset_len   (reset_len),
			.timeout     (timeout),
			.reset_out   (reset_out[i]),
			.done        (done[i]),
			.done_strobe (done_strobe[i]),
			.error       (error[i])
		);
	end

	// resets come in order, an earlier step never fires over a later one
	for (genvar i = 0; i < nstep - 1; i++) begin : g_order
		a_reset_order: assert property (@(posedge clk200) disable iff (rst)
			$rose(reset_out[i]) |-> (reset_out[nstep-1:i+1] == '0) || $past(start));
	end

endmodule

// ==== source/lb_regs.sv ====
`timescale 1ns/1ns

// local bus register block
// write takes effect next cycle, read reply one cycle after the command
module lb_regs #(
	parameter int nstep = 4
) (
	input  logic                clk200,
	input  logic                rst,
	input  reset_pkg::lb_cmd_t  lbwcmd,
	input  logic                lbwvalid,
	output reset_pkg::lb_cmd_t  lbrcmd,
	output logic                lbrready,
	input  logic [nstep-1:0]    done,
	input  logic [nstep-1:0]    error,
	input  logic [nstep-1:0]    done_criteria,
	output logic                seq_start,
	output reset_pkg::len_t     ready_len,
	output reset_pkg::len_t     reset_len,
	output reset_pkg::tmo_t     timeout
);

	reset_pkg::lb_addr_t cmd_addr;
	reset_pkg::lb_data_t cmd_data;
	logic                cmd_rd;    // read flag of the word
	logic                wr_en;
	logic                rd_en;
	reset_pkg::lb_data_t scratch;
	reset_pkg::lb_data_t status;
	reset_pkg::lb_data_t rd_data;

	// command word fields
	assign cmd_rd   = lbwcmd[reset_pkg::lb_read_bit];
	assign cmd_addr = lbwcmd[reset_pkg::lb_addr_msb:reset_pkg::lb_addr_lsb];
	assign cmd_data = lbwcmd[31:0];
	assign wr_en    = lbwvalid & ~cmd_rd;
	assign rd_en    = lbwvalid & cmd_rd;

	always_ff @(posedge clk200) begin
		if (rst) begin
			ready_len <= reset_pkg::ready_len_rst;
			reset_len <= reset_pkg::reset_len_rst;
			timeout   <= reset_pkg::timeout_rst;
			scratch   <= reset_pkg::scratch_rst;
			seq_start <= 1'b0;
		end else begin
			// one cycle strobe on ctrl bit 0
			seq_start <= wr_en && (cmd_addr == reset_pkg::addr_ctrl) && cmd_data[0];
			if (wr_en) begin
				case (cmd_addr)
					reset_pkg::addr_ready_len: ready_len <= reset_pkg::len_t'(cmd_data);
					reset_pkg::addr_reset_len: reset_len <= reset_pkg::len_t'(cmd_data);
					reset_pkg::addr_timeout:   timeout   <= cmd_data;
					reset_pkg::addr_scratch:   scratch   <= cmd_data;
					default: begin
						// ctrl handled above, others read only or unused
					end
				endcase
			end
		end
	end

	// status word, error high half, done low half
	always_comb begin
		status = '0;
		status[nstep-1:0] = done;
		status[16 +: nstep] = error;
	end

	// read mux
	always_comb begin
		case (cmd_addr)
			reset_pkg::addr_ready_len: rd_data = reset_pkg::lb_data_t'(ready_len);
			reset_pkg::addr_reset_len: rd_data = reset_pkg::lb_data_t'(reset_len);
			reset_pkg::addr_timeout:   rd_data = timeout;
			reset_pkg::addr_status:    rd_data = status;
			reset_pkg::addr_criteria:  rd_data = reset_pkg::lb_data_t'(done_criteria);
			reset_pkg::addr_scratch:   rd_data = scratch;
			default:                   rd_data = reset_pkg::bad_addr_data;  // ctrl too
		endcase
	end

	// reply strobe
	always_ff @(posedge clk200) begin
		if (rst) begin
			lbrready <= 1'b0;
		end else begin
			lbrready <= rd_en;
		end
	end

	// reply word holds until the next read
	always_ff @(posedge clk200) begin
		if (rd_en) begin
			lbrcmd <= {lbwcmd[63:reset_pkg::lb_addr_lsb], rd_data};  // echo upper half
		end
	end

	// no reply without a valid read word on the bus one cycle before
	a_reply_timing: assert property (@(posedge clk200) disable iff (rst)
		lbrready |-> $past(lbwvalid && lbwcmd[reset_pkg::lb_read_bit]));

endmodule

// ==== source/reset_pkg.sv ====
package reset_pkg;

	// local bus command word
	// [63] read flag, [55:32] address, [31:0] data
	typedef logic [63:0] lb_cmd_t;
	typedef logic [23:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;

	localparam int lb_read_bit = 63;   // 1 = read, 0 = write
	localparam int lb_addr_msb = 55;
	localparam int lb_addr_lsb = 32;   // also the low edge of the echoed half

	// cycle counts
	typedef logic [15:0] len_t;        // ready and reset lengths
	typedef logic [31:0] tmo_t;        // wait-for-done timeout, 0 disables

	// per step sequencer states
	typedef enum logic [2:0] {
		st_idle,                       // waiting for predecessor
		st_wait_ready,                 // qualifying ready input
		st_reset,                      // driving reset_out
		st_wait_done,                  // waiting on own criteria
		st_done,
		st_error                       // timed out, chain halts here
	} step_state_t;

	// register map
	localparam lb_addr_t addr_ctrl      = 24'd0;  // bit 0 starts the sequence
	localparam lb_addr_t addr_ready_len = 24'd1;
	localparam lb_addr_t addr_reset_len = 24'd2;
	localparam lb_addr_t addr_timeout   = 24'd3;
	localparam lb_addr_t addr_status    = 24'd4;  // error[31:16], done[15:0]
	localparam lb_addr_t addr_criteria  = 24'd5;  // live done criteria
	localparam lb_addr_t addr_scratch   = 24'd6;

	localparam lb_data_t bad_addr_data = 32'hdead_beef;

	// values after rst
	localparam len_t ready_len_rst = 16'd10;
	localparam len_t reset_len_rst = 16'd10;
	localparam tmo_t timeout_rst   = 32'd0;      // no timeout
	localparam lb_data_t scratch_rst = 32'd0;

endpackage

// ==== source/reset_step.sv ====
`timescale 1ns/1ns

// one link of the reset chain
// qualify ready, pulse reset, then wait for own criteria
module reset_step (
	input  logic              clk200,
	input  logic              rst,
	input  logic              start,        // begin or restart this step
	input  logic              ready_in,     // predecessor's done criteria
	input  logic              criteria,     // own done criteria, e.g. pll lock
	input  reset_pkg::len_t   ready_len,
	input  reset_pkg::len_t   reset_len,
	input  reset_pkg::tmo_t   timeout,      // 0 = wait forever
	output logic              reset_out,
	output logic              done,
	output logic              done_strobe,  // one cycle, starts next step
	output logic              error
);

	reset_pkg::step_state_t state;
	logic [31:0] cnt;        // ready run, reset width or timeout, per state
	logic [31:0] cnt_inc;
	logic        ready_hit;  // ready seen for ready_len cycles in a row
	logic        reset_hit;  // last cycle of the reset pulse
	logic        tmo_hit;    // last cycle allowed in wait_done

	assign cnt_inc   = cnt + 32'd1;
	assign ready_hit = cnt_inc >= 32'(ready_len);
	assign reset_hit = cnt_inc >= 32'(reset_len);
	assign tmo_hit   = (timeout != '0) && (cnt_inc >= timeout);

	always_ff @(posedge clk200) begin
		if (rst) begin
			state       <= reset_pkg::st_idle;
			cnt         <= '0;
			reset_out   <= 1'b0;
			done        <= 1'b0;
			done_strobe <= 1'b0;
			error       <= 1'b0;
		end else if (start) begin
			// restart from any state, also mid-sequence
			state       <= reset_pkg::st_wait_ready;
			cnt         <= '0;
			reset_out   <= 1'b0;
			done        <= 1'b0;
			done_strobe <= 1'b0;
			error       <= 1'b0;
		end else begin
			done_strobe <= 1'b0;  // single cycle
			case (state)
				reset_pkg::st_wait_ready: begin
					if (ready_in) begin
						if (ready_hit) begin
							state     <= reset_pkg::st_reset;
							cnt       <= '0;
							reset_out <= 1'b1;  // pulse starts next cycle
						end else begin
							cnt <= cnt_inc;
						end
					end else begin
						cnt <= '0;  // any low cycle restarts the run
					end
				end
				reset_pkg::st_reset: begin
					if (reset_hit) begin
						state     <= reset_pkg::st_wait_done;
						cnt       <= '0;
						reset_out <= 1'b0;
					end else begin
						cnt <= cnt_inc;
					end
				end
				reset_pkg::st_wait_done: begin
					// criteria wins over a timeout in the same cycle
					if (criteria) begin
						state       <= reset_pkg::st_done;
						done        <= 1'b1;
						done_strobe <= 1'b1;
					end else if (tmo_hit) begin
						state <= reset_pkg::st_error;
						error <= 1'b1;  // sticky until next start
					end else begin
						cnt <= cnt_inc;
					end
				end
				reset_pkg::st_idle, reset_pkg::st_done, reset_pkg::st_error: begin
					// hold until start or rst
				end
				default: begin
					state <= reset_pkg::st_idle;
				end
			endcase
		end
	end

	// registered reset_out must track the fsm
	a_reset_in_state: assert property (@(posedge clk200) disable iff (rst)
		reset_out |-> (state == reset_pkg::st_reset));

	// a step ends one way or the other, never both
	a_done_error_excl: assert property (@(posedge clk200) disable iff (rst)
		!(done && error));

endmodule
